/* miniCore.f */
src/miniCorePkg.sv
src/insnDecoder.sv
src/aluExec.sv
src/regFile.sv
src/coreSequencer.sv
src/miniCore.sv
sim/miniCore_sva.sv
sim/miniCore_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the miniCore testbench with Verilator

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module miniCore_tb -f miniCore.f -o miniCore_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/miniCore_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
    echo "No verdict found in $LOG"
    exit 1
fi

exit 0

/* sim/miniCore_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module miniCore_tb;

    logic                 clk = 1'b0;
    logic                 reset_n = 1'b0;
    miniCorePkg::word_t   insnAddr;
    miniCorePkg::word_t   insnData;
    miniCorePkg::memReq_t memReq;
    miniCorePkg::word_t   memRData;
    logic                 halted;

    miniCorePkg::word_t imem [0:255];
    miniCorePkg::word_t dmem [0:255];
    miniCorePkg::word_t storeAddr [$];
    miniCorePkg::word_t storeData [$];
    miniCorePkg::word_t fetchTrace [$];
    miniCorePkg::word_t prevAddr;
    int errors = 0;
    int checks = 0;
    int seed = 22444;
    int cycle = 0;
    int lastChange = -1;

    always #4 clk = ~clk;

    // Combinational memories indexed by the low 8 address bits
    assign insnData = imem[insnAddr[7:0]];
    assign memRData = dmem[memReq.addr[7:0]];

    miniCore #(
        .RESET_VECTOR (32'd16)
    ) miniCore_inst (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .o_insnAddr (insnAddr),
        .i_insnData (insnData),
        .o_memReq   (memReq),
        .i_memRData (memRData),
        .o_halted   (halted)
    );

    task automatic compareWord(input string name, input miniCorePkg::word_t got,
                               input miniCorePkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Monitor on the falling edge away from DUT updates
    always @(negedge clk) begin
        cycle++;
        if (!reset_n) begin
            lastChange = -1;
            prevAddr   = insnAddr;
        end else begin
            if (memReq.write) begin
                storeAddr.push_back(memReq.addr);
                storeData.push_back(memReq.wdata);
                dmem[memReq.addr[7:0]] = memReq.wdata;
            end
            if (insnAddr != prevAddr) begin
                if (lastChange >= 0)
                    compareWord("insnAddr step cycles", cycle - lastChange, 32'd3);
                lastChange = cycle;
                prevAddr   = insnAddr;
                fetchTrace.push_back(insnAddr);
            end
        end
    end

    function automatic miniCorePkg::word_t encodeInsn(input logic t, input logic [1:0] deref,
            input int z, input int x, input int y, input int op, input logic [11:0] imm);
        return {1'b0, t, deref, z[3:0], x[3:0], y[3:0], op[3:0], imm};
    endfunction

    function automatic miniCorePkg::word_t signExtend(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Reference result of each opcode
    function automatic miniCorePkg::word_t aluRef(input int op, input miniCorePkg::word_t a,
                                                  input miniCorePkg::word_t b);
        case (op)
            0:  return a | b;
            1:  return a & b;
            2:  return a + b;
            3:  return a * b;
            5:  return a << b;
            6:  return {32{$signed(a) < $signed(b)}};
            7:  return {32{a == b}};
            8:  return {32{$signed(a) > $signed(b)}};
            9:  return a & ~b;
            10: return a ^ b;
            11: return a - b;
            12: return ~(a ^ b);
            13: return a >> b;
            14: return {32{a != b}};
            default: return 32'd0;
        endcase
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'hFFFF_FFFF;           // Stray fetches halt
            dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
        end
    endtask

    task automatic pulseReset();
        @(posedge clk);
        #1 reset_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;
        storeAddr.delete();
        storeData.delete();
        fetchTrace.delete();
        compareWord("o_insnAddr after reset", insnAddr, 32'd16);
        compareBit("o_halted after reset", halted, 1'b0);
        compareBit("o_memReq.write after reset", memReq.write, 1'b0);
    endtask

    task automatic runToHalt();
        int n;
        n = 0;
        while (!halted && n < 2000) begin
            @(posedge clk);
            #1 n++;
        end
        if (!halted) begin
            errors++;
            $display("Core did not halt within 2000 cycles at %0t", $time);
        end
        @(negedge clk);
    endtask

    task automatic checkStores(input miniCorePkg::word_t expAddr [$],
                               input miniCorePkg::word_t expData [$]);
        compareWord("store count", storeAddr.size(), expAddr.size());
        for (int i = 0; i < expAddr.size() && i < storeAddr.size(); i++) begin
            compareWord("store addr", storeAddr[i], expAddr[i]);
            compareWord("store data", storeData[i], expData[i]);
        end
    endtask

    task automatic testAluOps();
        logic [11:0]        a;
        logic [11:0]        b;
        logic [11:0]        c;
        miniCorePkg::word_t exp;
        miniCorePkg::word_t ea [$];
        miniCorePkg::word_t ed [$];
        for (int op = 0; op < 16; op++) begin
            for (int t = 0; t < 2; t++) begin
                a = $random(seed);
                b = $random(seed);
                c = $random(seed);
                // Shift amounts below 32 so some bits survive
                if (op == 5 || op == 13) begin
                    b = b & 12'h01F;
                    c = c & 12'h01F;
                end
                // Equal operands in type 1 so EQ and NE also see a match
                if ((op == 7 || op == 14) && t == 1)
                    c = a;
                clearProgram();
                imem[16] = encodeInsn(0, 2'b00, 1, 0, 0, 0, a);
                imem[17] = encodeInsn(0, 2'b00, 2, 0, 0, 0, b);
                imem[18] = encodeInsn(t, 2'b00, 3, 1, 2, op, c);
                imem[19] = encodeInsn(0, 2'b11, 3, 0, 0, 0, 12'd100);
                imem[20] = encodeInsn(0, 2'b11, 0, 0, 0, 0, 12'd101);   // r0 reads zero
                if (t == 0)
                    exp = aluRef(op, signExtend(a), signExtend(b)) + signExtend(c);
                else
                    exp = aluRef(op, signExtend(a), signExtend(c)) + signExtend(b);
                ea = '{32'd100, 32'd101};
                ed = '{exp, 32'd0};
                pulseReset();
                runToHalt();
                checkStores(ea, ed);
            end
        end
    endtask

    task automatic testDeref();
        miniCorePkg::word_t v;
        miniCorePkg::word_t ea [$];
        miniCorePkg::word_t ed [$];
        clearProgram();
        v = $random(seed);
        imem[16] = encodeInsn(0, 2'b01, 1, 0, 0, 0, 12'd50);   // Load
        imem[17] = encodeInsn(0, 2'b00, 2, 0, 0, 0, 12'd60);
        imem[18] = encodeInsn(0, 2'b10, 2, 1, 0, 0, 12'd0);    // mem[Z] = result
        imem[19] = encodeInsn(0, 2'b11, 1, 0, 0, 0, 12'd70);   // mem[result] = Z
        pulseReset();
        dmem[50] = v;
        ea = '{32'd60, 32'd70};
        ed = '{v, v};
        runToHalt();
        checkStores(ea, ed);
    endtask

    task automatic testJump();
        miniCorePkg::word_t ea [$];
        miniCorePkg::word_t ed [$];
        clearProgram();
        imem[16] = encodeInsn(0, 2'b00, 15, 0, 0, 0, 12'd30);
        imem[30] = encodeInsn(0, 2'b11, 15, 0, 0, 0, 12'd80);  // Store pc plus one
        ea = '{32'd80};
        ed = '{32'd31};
        pulseReset();
        runToHalt();
        checkStores(ea, ed);
        compareWord("fetch trace size", fetchTrace.size(), 32'd2);
        if (fetchTrace.size() == 2) begin
            compareWord("jump target", fetchTrace[0], 32'd30);
            compareWord("after jump", fetchTrace[1], 32'd31);
        end
    endtask

    task automatic testIllegal();
        clearProgram();
        pulseReset();
        runToHalt();
        compareBit("o_halted", halted, 1'b1);
        compareWord("halt address", insnAddr, 32'd16);
        repeat (50) begin
            @(negedge clk);
            compareWord("o_insnAddr while halted", insnAddr, 32'd16);
            compareBit("o_memReq.write while halted", memReq.write, 1'b0);
        end
        compareWord("stores while halted", storeAddr.size(), 32'd0);
    endtask

    initial begin
        clearProgram();
        testAluOps();
        testDeref();
        testJump();
        testIllegal();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/miniCore_sva.sv */
`default_nettype none
`timescale 1ns/1ps

module miniCore_sva (
    input logic                i_clk,
    input logic                i_reset_n,
    input miniCorePkg::phase_t phase,
    input miniCorePkg::word_t  pc,
    input logic                halted,
    input logic                memWrite
);

    // Phase order decode, execute, writeback
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (phase == miniCorePkg::PH_DECODE && !halted) |=> phase == miniCorePkg::PH_EXEC)
        else $error("phase did not go from decode to execute");

    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (phase == miniCorePkg::PH_EXEC && !halted) |=> (phase == miniCorePkg::PH_WRITE || halted))
        else $error("phase did not go from execute to writeback");

    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (phase == miniCorePkg::PH_WRITE && !halted) |=> phase == miniCorePkg::PH_DECODE)
        else $error("phase did not go from writeback to decode");

    // PC moves only at the end of writeback
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (phase != miniCorePkg::PH_WRITE || halted) |=> $stable(pc))
        else $error("pc changed outside writeback");

    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        memWrite |-> (phase == miniCorePkg::PH_WRITE && !halted))
        else $error("write strobe outside writeback");

endmodule

bind coreSequencer miniCore_sva miniCore_sva_inst (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .phase     (phase),
    .pc        (pc),
    .halted    (halted),
    .memWrite  (o_memReq.write)
);

`default_nettype wire

/* src/miniCore.sv */
`default_nettype none
`timescale 1ns/1ps

module miniCore #(
    parameter miniCorePkg::word_t RESET_VECTOR = 32'd0
) (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    output miniCorePkg::word_t   o_insnAddr,
    input  miniCorePkg::word_t   i_insnData,
    output miniCorePkg::memReq_t o_memReq,
    input  miniCorePkg::word_t   i_memRData,
    output logic                 o_halted
);

    miniCorePkg::decodedInsn_t dec;
    miniCorePkg::word_t        valueX;
    miniCorePkg::word_t        valueY;
    miniCorePkg::word_t        valueZ;
    miniCorePkg::word_t        rhs;
    miniCorePkg::word_t        pc;
    miniCorePkg::word_t        regWData;
    logic                      aluLoad;
    logic                      regWrite;

    assign o_insnAddr = pc;   // Held for the whole instruction

    insnDecoder insnDecoder_inst (
        .i_insnData (i_insnData),
        .o_dec      (dec)
    );

    aluExec aluExec_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_load    (aluLoad),
        .i_dec     (dec),
        .i_valueX  (valueX),
        .i_valueY  (valueY),
        .o_rhs     (rhs)
    );

    regFile regFile_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_idxX    (dec.idxX),
        .i_idxY    (dec.idxY),
        .i_idxZ    (dec.idxZ),
        .i_pc      (pc),
        .i_write   (regWrite),
        .i_wdata   (regWData),
        .o_valueX  (valueX),
        .o_valueY  (valueY),
        .o_valueZ  (valueZ)
    );

    coreSequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) coreSequencer_inst (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_dec      (dec),
        .i_rhs      (rhs),
        .i_valueZ   (valueZ),
        .i_memRData (i_memRData),
        .o_pc       (pc),
        .o_aluLoad  (aluLoad),
        .o_regWrite (regWrite),
        .o_regWData (regWData),
        .o_memReq   (o_memReq),
        .o_halted   (o_halted)
    );

endmodule

`default_nettype wire

/* src/coreSequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module coreSequencer #(
    parameter miniCorePkg::word_t RESET_VECTOR = 32'd0
) (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  miniCorePkg::decodedInsn_t i_dec,
    input  miniCorePkg::word_t        i_rhs,
    input  miniCorePkg::word_t        i_valueZ,
    input  miniCorePkg::word_t        i_memRData,
    output miniCorePkg::word_t        o_pc,
    output logic                      o_aluLoad,
    output logic                      o_regWrite,
    output miniCorePkg::word_t        o_regWData,
    output miniCorePkg::memReq_t      o_memReq,
    output logic                      o_halted
);

    miniCorePkg::phase_t phase;
    miniCorePkg::word_t  pc;
    miniCorePkg::word_t  wbValue;
    logic                halted;
    logic                inWrite;

    assign inWrite = (phase == miniCorePkg::PH_WRITE) && !halted;

    // Mode 01 loads from memory, otherwise the ALU result
    assign wbValue = i_dec.deref[0] ? i_memRData : i_rhs;

    assign o_pc       = pc;
    assign o_halted   = halted;
    assign o_aluLoad  = (phase == miniCorePkg::PH_EXEC) && !halted;
    assign o_regWrite = inWrite && i_dec.regWrite;
    assign o_regWData = wbValue;

    always_comb begin
        o_memReq = '0;
        if (i_dec.memActive) begin
            // Address is the result unless storing to Z
            o_memReq.addr  = i_dec.deref[0] ? i_rhs : i_valueZ;
            o_memReq.wdata = i_dec.deref[0] ? i_valueZ : i_rhs;
            o_memReq.write = inWrite && i_dec.memWrite;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            phase  <= miniCorePkg::PH_DECODE;
            pc     <= RESET_VECTOR;
            halted <= 1'b0;
        end else if (!halted) begin
            case (phase)
                miniCorePkg::PH_DECODE: begin
                    phase <= miniCorePkg::PH_EXEC;
                end
                miniCorePkg::PH_EXEC: begin
                    if (i_dec.illegal) begin
                        halted <= 1'b1;   // Stays put until reset
                    end else begin
                        phase <= miniCorePkg::PH_WRITE;
                    end
                end
                miniCorePkg::PH_WRITE: begin
                    pc    <= i_dec.jump ? wbValue : pc + 32'd1;
                    phase <= miniCorePkg::PH_DECODE;
                end
                default: begin
                    phase <= miniCorePkg::PH_DECODE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/regFile.sv */
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  miniCorePkg::regIdx_t i_idxX,
    input  miniCorePkg::regIdx_t i_idxY,
    input  miniCorePkg::regIdx_t i_idxZ,
    input  miniCorePkg::word_t   i_pc,
    input  logic                 i_write,
    input  miniCorePkg::word_t   i_wdata,
    output miniCorePkg::word_t   o_valueX,
    output miniCorePkg::word_t   o_valueY,
    output miniCorePkg::word_t   o_valueZ
);

    miniCorePkg::word_t store [1:14];
    miniCorePkg::word_t pcNext;

    assign pcNext = i_pc + 32'd1;

    function automatic miniCorePkg::word_t readReg(input miniCorePkg::regIdx_t idx);
        if (idx == miniCorePkg::REG_ZERO)
            return '0;
        else if (idx == miniCorePkg::REG_PC)
            return pcNext;    // PC reads as pc plus one
        else
            return store[idx];
    endfunction

    assign o_valueX = readReg(i_idxX);
    assign o_valueY = readReg(i_idxY);
    assign o_valueZ = readReg(i_idxZ);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                store[i] <= '0;
            end
        end else if (i_write && i_idxZ != miniCorePkg::REG_ZERO
                     && i_idxZ != miniCorePkg::REG_PC) begin
            store[i_idxZ] <= i_wdata;   // PC writes are handled as jumps
        end
    end

endmodule

`default_nettype wire

/* src/aluExec.sv */
`default_nettype none
`timescale 1ns/1ps

module aluExec (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_load,
    input  miniCorePkg::decodedInsn_t i_dec,
    input  miniCorePkg::word_t        i_valueX,
    input  miniCorePkg::word_t        i_valueY,
    output miniCorePkg::word_t        o_rhs
);

    miniCorePkg::word_t immExt;
    miniCorePkg::word_t opB;      // Second operand of op
    miniCorePkg::word_t addend;   // Term added after op
    miniCorePkg::word_t opResult;
    logic signed [31:0] sX;
    logic signed [31:0] sB;

    assign immExt = {{20{i_dec.imm[11]}}, i_dec.imm};

    // Type 1 swaps roles of Y and the immediate
    assign opB    = i_dec.insnType ? immExt : i_valueY;
    assign addend = i_dec.insnType ? i_valueY : immExt;

    assign sX = i_valueX;
    assign sB = opB;

    always_comb begin
        case (i_dec.op)
            miniCorePkg::ALU_OR:   opResult = i_valueX | opB;
            miniCorePkg::ALU_AND:  opResult = i_valueX & opB;
            miniCorePkg::ALU_ADD:  opResult = i_valueX + opB;
            miniCorePkg::ALU_MUL:  opResult = i_valueX * opB;   // Low word only
            miniCorePkg::ALU_SHL:  opResult = i_valueX << opB;
            miniCorePkg::ALU_LT:   opResult = {32{sX < sB}};    // Signed compares
            miniCorePkg::ALU_EQ:   opResult = {32{i_valueX == opB}};
            miniCorePkg::ALU_GT:   opResult = {32{sX > sB}};
            miniCorePkg::ALU_ANDN: opResult = i_valueX & ~opB;
            miniCorePkg::ALU_XOR:  opResult = i_valueX ^ opB;
            miniCorePkg::ALU_SUB:  opResult = i_valueX - opB;
            miniCorePkg::ALU_XNOR: opResult = i_valueX ^~ opB;
            miniCorePkg::ALU_SHR:  opResult = i_valueX >> opB;  // Logical
            miniCorePkg::ALU_NE:   opResult = {32{i_valueX != opB}};
            default:               opResult = '0;               // Reserved codes
        endcase
    end

    // Result captured at end of execute phase
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_rhs <= '0;
        end else if (i_load) begin
            o_rhs <= opResult + addend;
        end
    end

endmodule

`default_nettype wire

/* src/insnDecoder.sv */
`default_nettype none
`timescale 1ns/1ps

module insnDecoder (
    input  miniCorePkg::word_t        i_insnData,
    output miniCorePkg::decodedInsn_t o_dec
);

    logic                 insnType;
    logic [1:0]           deref;
    miniCorePkg::regIdx_t idxZ;
    logic                 illegal;
    logic                 regWrite;

    // Field extraction
    assign insnType = i_insnData[30];
    assign deref    = i_insnData[29:28];
    assign idxZ     = i_insnData[27:24];
    assign illegal  = &i_insnData;    // All ones halts the core

    // Register 0 is never written
    assign regWrite = !deref[1] && (idxZ != miniCorePkg::REG_ZERO);

    always_comb begin
        o_dec           = '0;
        o_dec.insnType  = insnType;
        o_dec.deref     = deref;
        o_dec.idxZ      = idxZ;
        o_dec.idxX      = i_insnData[23:20];
        o_dec.idxY      = i_insnData[19:16];
        o_dec.op        = i_insnData[15:12];
        o_dec.imm       = i_insnData[11:0];
        o_dec.memActive = (deref != 2'b00) && !illegal;
        o_dec.memWrite  = deref[1];
        o_dec.regWrite  = regWrite;
        o_dec.jump      = regWrite && (idxZ == miniCorePkg::REG_PC);
        o_dec.illegal   = illegal;
    end

endmodule

`default_nettype wire

/* src/miniCorePkg.sv */
`default_nettype none

package miniCorePkg;

    typedef logic [31:0] word_t;        // Data word or address
    typedef logic [3:0]  regIdx_t;      // Register index
    typedef logic signed [11:0] imm_t;  // Immediate field
    typedef logic [3:0]  aluOp_t;

    // Register indices with special meaning
    localparam regIdx_t REG_ZERO = 4'd0;
    localparam regIdx_t REG_PC   = 4'd15;

    // Opcodes, 4 and 15 reserved
    localparam aluOp_t ALU_OR   = 4'd0;
    localparam aluOp_t ALU_AND  = 4'd1;
    localparam aluOp_t ALU_ADD  = 4'd2;
    localparam aluOp_t ALU_MUL  = 4'd3;
    localparam aluOp_t ALU_SHL  = 4'd5;
    localparam aluOp_t ALU_LT   = 4'd6;
    localparam aluOp_t ALU_EQ   = 4'd7;
    localparam aluOp_t ALU_GT   = 4'd8;
    localparam aluOp_t ALU_ANDN = 4'd9;
    localparam aluOp_t ALU_XOR  = 4'd10;
    localparam aluOp_t ALU_SUB  = 4'd11;
    localparam aluOp_t ALU_XNOR = 4'd12;
    localparam aluOp_t ALU_SHR  = 4'd13;
    localparam aluOp_t ALU_NE   = 4'd14;

    typedef enum logic [1:0] {
        PH_DECODE = 2'd0,
        PH_EXEC   = 2'd1,
        PH_WRITE  = 2'd2
    } phase_t;

    typedef struct packed {
        logic    insnType;   // 0: (X op Y) + I, 1: (X op I) + Y
        logic [1:0] deref;
        regIdx_t idxZ;
        regIdx_t idxX;
        regIdx_t idxY;
        aluOp_t  op;
        imm_t    imm;
        logic    memActive;
        logic    memWrite;
        logic    regWrite;
        logic    jump;       // Register write to PC
        logic    illegal;
    } decodedInsn_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } memReq_t;

endpackage

`default_nettype wire
